// ==== hw/icache_pkg.sv ====
// Bus command codes, memory tag type, address fields, cache geometry and memory line union
package icache_pkg;

    //////////////////////////////
    // Memory bus
    //////////////////////////////

    // Command encoding shared by both bus clients
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,       // Idle bus
        BUS_LOAD  = 2'h1,       // Line read
        BUS_STORE = 2'h2        // Line write, dcache only
    } bus_cmd_t;

    localparam int MEM_TAGS = 16;                   // Tag values, 0 reserved
    typedef logic [$clog2(MEM_TAGS)-1:0] mem_tag_t;  // Zero means no tag

    //////////////////////////////
    // Address fields
    //////////////////////////////

    // Byte address layout
    // [31:16] zero | [15:8] tag | [7:3] index | [2:0] zero offset
    localparam int OFFSET_W = 3;                      // Byte offset in a line
    localparam int INDEX_W  = 5;                      // Line select
    localparam int TAG_W    = 8;                      // Stored with each line
    localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;   // Significant bits, 16

    // Tag and index together, unit of sequential prefetch
    localparam int LINE_NUM_W = TAG_W + INDEX_W;

    //////////////////////////////
    // Cache geometry
    //////////////////////////////

    localparam int LINE_COUNT     = 1 << INDEX_W;   // Direct mapped, 32 lines
    localparam int PREFETCH_LINES = 4;              // Window ahead of the fetch line

    // One memory line
    // Raw word on the bus side, two instructions on the fetch side
    typedef union packed {
        logic [63:0]      word;     // Bus view
        logic [1:0][31:0] insn;     // insn[0] at the lower address
    } mem_line_t;

endpackage

// ==== hw/icache_array.sv ====
// Instruction cache line storage with tags, valid bits, two fetch lanes, lookup and fill port
`timescale 1ns/1ns

module icache_array (
    input  logic                             clock,
    input  logic                             reset,
    // Fetch side
    input  logic [31:0]                      fetch_addr,
    output icache_pkg::mem_line_t [1:0]      icache_data_out,   // Lane 0 fetch line, lane 1 next
    output logic [1:0]                       data_valid,
    // Prefetch lookup
    input  logic [icache_pkg::LINE_NUM_W-1:0] lookup_line,
    output logic                             lookup_hit,
    // Fill from memory port
    input  logic                             fill_valid,
    input  logic [icache_pkg::INDEX_W-1:0]   fill_index,
    input  logic [icache_pkg::TAG_W-1:0]     fill_tag,
    input  icache_pkg::mem_line_t            fill_line
);
    import icache_pkg::*;

    mem_line_t             line_data [LINE_COUNT];   // Instruction pairs
    logic [TAG_W-1:0]      line_tag [LINE_COUNT];
    logic [LINE_COUNT-1:0] line_valid;
    logic [1:0][LINE_NUM_W-1:0] lane_line;           // Line numbers of both fetch lanes

    // Valid and tag compare for one line number
    function automatic logic line_hit(input logic [LINE_NUM_W-1:0] line);
        logic [INDEX_W-1:0] idx;
        idx = line[INDEX_W-1:0];
        return line_valid[idx] && (line_tag[idx] == line[LINE_NUM_W-1:INDEX_W]);
    endfunction

    //////////////////////////////
    // Read ports
    //////////////////////////////

    always_comb begin
        lane_line[0] = fetch_addr[ADDR_W-1:OFFSET_W];
        lane_line[1] = lane_line[0] + LINE_NUM_W'(1);   // Next sequential line
        for (int lane = 0; lane < 2; lane++) begin
            icache_data_out[lane] = line_data[lane_line[lane][INDEX_W-1:0]];
            data_valid[lane]      = line_hit(lane_line[lane]);
        end
        // Sequencer probe, same compare as fetch
        lookup_hit = line_hit(lookup_line);
    end

    //////////////////////////////
    // Fill port
    //////////////////////////////

    // Valid bits cleared by reset and set by fills
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_valid) begin
            line_valid[fill_index] <= 1'b1;    // Readable from next cycle
        end
    end

    // Data and tag overwrite on fill
    always_ff @(posedge clock) begin
        if (fill_valid) begin
            line_data[fill_index] <= fill_line;
            line_tag[fill_index]  <= fill_tag;   // Evicts whatever lived here
        end
    end

endmodule

// ==== hw/prefetch_sequencer.sv ====
// Prefetch window sequencer issuing icache line reads for missing lines near the fetch line
`timescale 1ns/1ns

module prefetch_sequencer (
    input  logic                              clock,
    input  logic                              reset,
    // Fetch side
    input  logic [31:0]                       fetch_addr,
    input  logic                              fetch_valid,
    // Array lookup
    output logic [icache_pkg::LINE_NUM_W-1:0] lookup_line,
    input  logic                              lookup_hit,
    // Memory port
    input  logic [icache_pkg::LINE_COUNT-1:0] pending_lines,    // Indices with fills in flight
    input  icache_pkg::mem_tag_t              icache_response,  // Nonzero on accept
    output logic                              icache_read,
    output logic [31:0]                       icache_addr
);
    import icache_pkg::*;

    logic [$clog2(PREFETCH_LINES)-1:0] window_offset;   // Registered scan position
    logic [$clog2(PREFETCH_LINES)-1:0] scan_offset;     // Position used this cycle
    logic [$clog2(PREFETCH_LINES)-1:0] next_offset;
    logic [LINE_NUM_W-1:0] fetch_line;
    logic [LINE_NUM_W-1:0] last_line;                   // Fetch line seen last cycle
    logic                  last_valid;
    logic                  line_changed;
    logic                  skip_line;                   // Present or already requested

    //////////////////////////////
    // Window scan
    //////////////////////////////

    assign fetch_line   = fetch_addr[ADDR_W-1:OFFSET_W];
    assign line_changed = !last_valid || (fetch_line != last_line);
    assign scan_offset  = line_changed ? '0 : window_offset;   // Restart on a new fetch line

    assign lookup_line = fetch_line + LINE_NUM_W'(scan_offset);
    assign skip_line   = lookup_hit || pending_lines[lookup_line[INDEX_W-1:0]];

    // Miss with no fill outstanding on its index, bus left idle in reset
    assign icache_read = fetch_valid && !reset && !skip_line;
    assign icache_addr = {{(32 - ADDR_W){1'b0}}, lookup_line, {OFFSET_W{1'b0}}};

    // Advance past skipped lines, otherwise only on accept
    // Rejected or lost to the dcache -> same request again next cycle
    always_comb begin
        next_offset = scan_offset;
        if (skip_line || (icache_response != '0)) begin
            if (scan_offset == PREFETCH_LINES - 1) begin
                next_offset = '0;              // Wrap, rescan the window
            end else begin
                next_offset = scan_offset + 1'b1;
            end
        end
    end

    //////////////////////////////
    // State
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            window_offset <= '0;
            last_valid    <= 1'b0;
        end else begin
            window_offset <= fetch_valid ? next_offset : '0;   // Idle fetch parks at 0
            last_valid    <= fetch_valid;
        end
    end

    // Fetch line of the previous cycle
    always_ff @(posedge clock) begin
        last_line <= fetch_line;
    end

endmodule

// ==== hw/mem_port.sv ====
// Memory bus arbiter with dcache priority, outstanding icache tag table and fill matching
`timescale 1ns/1ns

module mem_port (
    input  logic                              clock,
    input  logic                              reset,
    // Data cache client
    input  icache_pkg::bus_cmd_t              dcache2mem_command,
    input  logic [31:0]                       dcache2mem_addr,
    output icache_pkg::mem_tag_t              dcache_response,
    // Instruction cache client
    input  logic                              icache_read,
    input  logic [31:0]                       icache_addr,
    output icache_pkg::mem_tag_t              icache_response,
    // Memory bus
    output icache_pkg::bus_cmd_t              proc2mem_command,
    output logic [31:0]                       proc2mem_addr,
    input  icache_pkg::mem_tag_t              mem2proc_response,
    input  icache_pkg::mem_tag_t              mem2proc_tag,
    input  logic [63:0]                       mem2proc_data,
    // Cache side
    output logic [icache_pkg::LINE_COUNT-1:0] pending_lines,
    output logic                              fill_valid,
    output logic [icache_pkg::INDEX_W-1:0]    fill_index,
    output logic [icache_pkg::TAG_W-1:0]      fill_tag,
    output icache_pkg::mem_line_t             fill_line
);
    import icache_pkg::*;

    logic                  dcache_active;          // Dcache owns the bus this cycle
    logic                  icache_accept;
    logic [INDEX_W-1:0]    req_index;
    logic [TAG_W-1:0]      req_tag;
    logic [MEM_TAGS-1:0]   entry_valid;            // One entry per memory tag
    logic [INDEX_W-1:0]    entry_index [MEM_TAGS];
    logic [TAG_W-1:0]      entry_tag [MEM_TAGS];

    //////////////////////////////
    // Arbitration
    //////////////////////////////

    assign dcache_active = (dcache2mem_command != BUS_NONE);

    always_comb begin
        if (dcache_active) begin
            proc2mem_command = dcache2mem_command;
            proc2mem_addr    = dcache2mem_addr;
            dcache_response  = mem2proc_response;
            icache_response  = '0;                      // Icache lost, retries
        end else begin
            proc2mem_command = icache_read ? BUS_LOAD : BUS_NONE;
            proc2mem_addr    = icache_addr;
            dcache_response  = '0;
            icache_response  = icache_read ? mem2proc_response : '0;
        end
    end

    //////////////////////////////
    // Outstanding tag table
    //////////////////////////////

    assign icache_accept = (icache_response != '0);
    assign req_index     = icache_addr[OFFSET_W +: INDEX_W];
    assign req_tag       = icache_addr[OFFSET_W + INDEX_W +: TAG_W];

    // Returning data belongs to the icache only if its tag is recorded here
    assign fill_valid     = (mem2proc_tag != '0) && entry_valid[mem2proc_tag];
    assign fill_index     = entry_index[mem2proc_tag];
    assign fill_tag       = entry_tag[mem2proc_tag];
    assign fill_line.word = mem2proc_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid   <= '0;
            pending_lines <= '0;
        end else begin
            // Retire first so a reused tag in the same cycle stays live
            if (fill_valid) begin
                entry_valid[mem2proc_tag] <= 1'b0;
                pending_lines[fill_index] <= 1'b0;
            end
            if (icache_accept) begin
                entry_valid[icache_response] <= 1'b1;
                pending_lines[req_index]     <= 1'b1;
            end
        end
    end

    // Line address kept per tag
    always_ff @(posedge clock) begin
        if (icache_accept) begin
            entry_index[icache_response] <= req_index;
            entry_tag[icache_response]   <= req_tag;
        end
    end

endmodule

// ==== hw/icache_subsystem.sv ====
// Top level wiring of the icache array, prefetch sequencer and memory port
`timescale 1ns/1ns

module icache_subsystem (
    input  logic                         clock,
    input  logic                         reset,
    // Fetch side
    input  logic [31:0]                  fetch_addr,
    input  logic                         fetch_valid,
    output icache_pkg::mem_line_t [1:0]  icache_data_out,
    output logic [1:0]                   data_valid,
    // Data cache client
    input  icache_pkg::bus_cmd_t         dcache2mem_command,
    input  logic [31:0]                  dcache2mem_addr,
    output icache_pkg::mem_tag_t         dcache_response,
    // Memory bus
    output icache_pkg::bus_cmd_t         proc2mem_command,
    output logic [31:0]                  proc2mem_addr,
    input  icache_pkg::mem_tag_t         mem2proc_response,
    input  logic [63:0]                  mem2proc_data,
    input  icache_pkg::mem_tag_t         mem2proc_tag
);
    import icache_pkg::*;

    // Sequencer <-> array
    logic [LINE_NUM_W-1:0] lookup_line;
    logic                  lookup_hit;
    // Sequencer <-> memory port
    logic                  icache_read;
    logic [31:0]           icache_addr;
    mem_tag_t              icache_response;
    logic [LINE_COUNT-1:0] pending_lines;
    // Memory port -> array
    logic                  fill_valid;
    logic [INDEX_W-1:0]    fill_index;
    logic [TAG_W-1:0]      fill_tag;
    mem_line_t             fill_line;

    icache_array icache_array_inst (
        .clock, .reset,
        .fetch_addr, .icache_data_out, .data_valid,
        .lookup_line, .lookup_hit,
        .fill_valid, .fill_index, .fill_tag, .fill_line
    );

    prefetch_sequencer prefetch_sequencer_inst (
        .clock, .reset,
        .fetch_addr, .fetch_valid,
        .lookup_line, .lookup_hit,
        .pending_lines, .icache_response,
        .icache_read, .icache_addr
    );

    mem_port mem_port_inst (
        .clock, .reset,
        .dcache2mem_command, .dcache2mem_addr, .dcache_response,
        .icache_read, .icache_addr, .icache_response,
        .proc2mem_command, .proc2mem_addr,
        .mem2proc_response, .mem2proc_tag, .mem2proc_data,
        .pending_lines, .fill_valid, .fill_index, .fill_tag, .fill_line
    );

endmodule

// ==== tests/icache_assertions.sv ====
// Bound concurrent checks on memory bus arbitration and reset state of the icache subsystem
`timescale 1ns/1ns

module icache_assertions (
    input logic                              clock,
    input logic                              reset,
    input icache_pkg::bus_cmd_t              dcache2mem_command,
    input logic [31:0]                       dcache2mem_addr,
    input icache_pkg::mem_tag_t              dcache_response,
    input icache_pkg::mem_tag_t              icache_response,
    input icache_pkg::bus_cmd_t              proc2mem_command,
    input logic [31:0]                       proc2mem_addr,
    input icache_pkg::mem_tag_t              mem2proc_response,
    input logic [icache_pkg::LINE_COUNT-1:0] pending_lines,
    input logic [1:0]                        data_valid
);
    import icache_pkg::*;

    // Dcache owns the bus and the response, icache sees no tag
    assert property (@(posedge clock) disable iff (reset)
        (dcache2mem_command != BUS_NONE) |->
            (proc2mem_command == dcache2mem_command) && (proc2mem_addr == dcache2mem_addr)
            && (dcache_response == mem2proc_response) && (icache_response == '0))
        else $error("dcache priority lost on the memory bus");

    // No icache traffic in reset, even with fetch active
    assert property (@(posedge clock)
        (reset && dcache2mem_command == BUS_NONE) |-> (proc2mem_command == BUS_NONE))
        else $error("memory bus not idle during reset");

    assert property (@(posedge clock) reset |=> (pending_lines == '0) && (data_valid == 2'b00))
        else $error("cache state not cleared by reset");

endmodule

bind icache_subsystem icache_assertions icache_assertions_inst (.*);

// ==== tests/icache_tb.sv ====
// Testbench for the icache subsystem with LFSR stimulus, memory responder model and checks
`timescale 1ns/1ns

module icache_tb;
    import icache_pkg::*;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 4000;
    localparam int PHASE_MIN    = 40;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + RUN_CYCLES + 200) * 2 * HALF_PERIOD;

    logic            clock, reset, fetch_valid;
    logic [31:0]     fetch_addr, dcache2mem_addr, proc2mem_addr;
    mem_line_t [1:0] icache_data_out;
    logic [1:0]      data_valid;
    bus_cmd_t        dcache2mem_command, proc2mem_command;
    mem_tag_t        dcache_response, mem2proc_response, mem2proc_tag;
    logic [63:0]     mem2proc_data;

    // Responder model state per memory tag
    logic        tag_busy [MEM_TAGS];
    logic        tag_icache [MEM_TAGS];   // Issued with the dcache idle
    logic [31:0] tag_addr [MEM_TAGS];
    int          tag_due [MEM_TAGS];      // Earliest return cycle
    int          now, error_count, check_count;
    logic [15:0] lfsr_state = 16'd48643;

    icache_subsystem icache_subsystem_inst (.*);

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);   // Taps 16 14 13 11
    endfunction

    function automatic logic [63:0] rand_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);   // One step per bit
            value      = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Lower instruction is the line byte address and the upper one its inverse
    function automatic logic [63:0] line_image(input logic [LINE_NUM_W-1:0] line);
        logic [31:0] addr;
        addr = {16'h0, line, 3'b000};
        return {~addr, addr};
    endfunction

    task automatic expect_equal(input logic [63:0] actual, input logic [63:0] expected,
                                input string what);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic expect_true(input logic condition, input string what);
        check_count++;
        assert (condition) else begin
            error_count++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    //////////////////////////////
    // Memory responder
    //////////////////////////////

    // Offer the lowest free tag, return the lowest due tag
    task automatic drive_memory();
        int offer;
        int ret;
        offer = 0;
        ret   = 0;
        for (int t = MEM_TAGS - 1; t > 0; t--) begin
            if (!tag_busy[t]) begin
                offer = t;
            end else if (tag_due[t] <= now) begin
                ret = t;
            end
        end
        if (rand_bits(2) == 0) begin
            offer = 0;                           // Reject about one in four
        end
        mem2proc_response = mem_tag_t'(offer);
        mem2proc_tag      = mem_tag_t'(ret);
        mem2proc_data     = (ret != 0) ? line_image(tag_addr[ret][15:3]) : rand_bits(64);
    endtask

    task automatic update_model();
        if (mem2proc_tag != 0) begin
            tag_busy[mem2proc_tag] = 1'b0;       // Line delivered this cycle
        end
        if (proc2mem_command != BUS_NONE && mem2proc_response != 0) begin
            tag_busy[mem2proc_response]   = 1'b1;
            tag_icache[mem2proc_response] = (dcache2mem_command == BUS_NONE);
            tag_addr[mem2proc_response]   = proc2mem_addr;
            tag_due[mem2proc_response]    = now + 1 + int'(rand_bits(3));   // 1 to 8 later
        end
        now++;
    endtask

    //////////////////////////////
    // Per cycle checks
    //////////////////////////////

    task automatic check_cycle(input logic [LINE_NUM_W-1:0] fetch_line);
        logic [LINE_NUM_W-1:0] lane_line;
        logic [LINE_NUM_W-1:0] distance;
        logic                  index_busy;
        for (int lane = 0; lane < 2; lane++) begin
            lane_line = fetch_line + LINE_NUM_W'(lane);   // Lane 1 is the next line
            if (data_valid[lane]) begin
                expect_equal(icache_data_out[lane].word, line_image(lane_line),
                             $sformatf("lane %0d data", lane));
            end
        end
        if (dcache2mem_command != BUS_NONE) begin
            expect_equal(proc2mem_command, dcache2mem_command, "bus command");
            expect_equal(proc2mem_addr, dcache2mem_addr, "bus address");
            expect_equal(dcache_response, mem2proc_response, "dcache response");
        end else if (proc2mem_command == BUS_LOAD) begin
            distance   = proc2mem_addr[15:3] - fetch_line;
            index_busy = 1'b0;
            for (int t = 1; t < MEM_TAGS; t++) begin
                if (tag_busy[t] && tag_icache[t] && tag_addr[t][7:3] == proc2mem_addr[7:3]) begin
                    index_busy = 1'b1;
                end
            end
            expect_true(proc2mem_addr[31:16] == 0 && proc2mem_addr[2:0] == 0
                        && distance < PREFETCH_LINES, "icache request outside the window");
            expect_true(!index_busy, "icache request for an index with a fill in flight");
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: stimulus did not complete within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0]           phase_addr;
        logic [LINE_NUM_W-1:0] fetch_line;
        int                    phase_len;
        int                    done;
        reset              = 1'b1;
        fetch_valid        = 1'b1;              // Fetch active while reset holds the bus idle
        fetch_addr         = '0;
        dcache2mem_command = BUS_NONE;
        dcache2mem_addr    = '0;
        mem2proc_response  = '0;
        mem2proc_tag       = '0;
        mem2proc_data      = '0;
        error_count        = 0;
        check_count        = 0;
        now                = 0;
        done               = 0;
        for (int t = 0; t < MEM_TAGS; t++) begin
            tag_busy[t] = 1'b0;
        end
        repeat (RESET_CYCLES) @(negedge clock);
        reset       = 1'b0;
        fetch_valid = 1'b0;                     // Fetch idle in the first cycle
        #(HALF_PERIOD - 10);
        expect_equal(data_valid, 2'b00, "data_valid after reset");
        expect_equal(proc2mem_command, BUS_NONE, "bus command after reset");

        while (done < RUN_CYCLES) begin
            // 16 line region, 4 tags over 4 indices, window spills into the next tag
            phase_len  = PHASE_MIN + int'(rand_bits(8) % 161);
            fetch_line = {8'h40 + 8'(rand_bits(2)), 3'b111, 2'(rand_bits(2))};
            phase_addr = {16'h0, fetch_line, 1'(rand_bits(1)), 2'b00};
            for (int p = 0; p < phase_len && done < RUN_CYCLES; p++) begin
                @(negedge clock);
                fetch_valid = 1'b1;
                fetch_addr  = phase_addr;
                if (rand_bits(3) == 7) begin
                    dcache2mem_command = BUS_LOAD;      // Occasional dcache load
                    dcache2mem_addr    = {16'h0, 13'(rand_bits(13)), 3'b000};
                end else begin
                    dcache2mem_command = BUS_NONE;
                    dcache2mem_addr    = '0;
                end
                drive_memory();
                #(HALF_PERIOD - 10);                    // Settled, just before the edge
                check_cycle(fetch_line);
                if (p == phase_len - 1) begin
                    expect_equal(data_valid, 2'b11, "data_valid at end of phase");
                end
                update_model();
                done++;
            end
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/icache_pkg.sv
hw/icache_array.sv
hw/prefetch_sequencer.sv
hw/mem_port.sv
hw/icache_subsystem.sv
tests/icache_assertions.sv
tests/icache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module icache_tb -f vlog.f -o icache_sim

output=$(./obj_dir/icache_sim 2>&1) || true
echo "$output"

if grep -q "Simulation passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
